// ==== common/anpc_pkg.sv ====
package anpc_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int DELAY_WIDTH = 8; // Bits of every dwell time

    typedef logic [DELAY_WIDTH-1:0] dwell_t;   // Dwell in clock cycles
    typedef logic [5:0]             gate_word_t; // Upper group [5:3], lower group [2:0]
    typedef logic [1:0]             step_idx_t;  // Up to four steps per sequence

    //////////////////////////////////////////////////
    // Enumerations
    //////////////////////////////////////////////////

    // Switching states of one ANPC leg
    typedef enum logic [2:0] {
        P,
        Z_U2,
        Z_U1,
        Z_L1,
        Z_L2,
        N
    } anpc_state_t;

    // Requested output level
    typedef enum logic [1:0] {
        V_ZERO = 2'd0,
        V_POS  = 2'd1,
        V_NEG  = 2'd2
    } v_level_t;

    // Commutation type, picks the zero state
    typedef enum logic [1:0] {
        TYPE_I,
        TYPE_II,
        TYPE_III
    } comm_type_t;

    // Which dwell time a step holds for
    typedef enum logic [1:0] {
        DW_SHORT,
        DW_OFF_ON,
        DW_ON_OFF_V0,
        DW_OFF_ON_I0
    } dwell_sel_t;

    //////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////

    typedef struct packed {
        dwell_t t_short;
        dwell_t t_off_on;
        dwell_t t_on_off_v0;
        dwell_t t_off_on_i0;
    } dwell_set_t;

    // One step of a commutation sequence
    typedef struct packed {
        gate_word_t gates;
        dwell_sel_t dwell;
        logic       last;  // Final step of the sequence
    } comm_step_t;

    localparam anpc_state_t RESET_STATE = Z_U2;

endpackage

// ==== src/target_select.sv ====
`timescale 1ns/10ps

module target_select import anpc_pkg::*; (
    input  anpc_state_t state,
    input  v_level_t    level,
    input  comm_type_t  comm_type,
    output anpc_state_t target
);

    always_comb begin
        target = state;  // Stay unless a rule below applies
        case (state)
            P: begin
                if (level == V_ZERO) begin
                    case (comm_type)
                        TYPE_II:  target = Z_L2;
                        TYPE_III: target = Z_L1;
                        default:  target = Z_U2;  // Type I and unknown codes
                    endcase
                end
            end

            N: begin
                if (level == V_ZERO) begin
                    case (comm_type)
                        TYPE_II:  target = Z_U2;
                        TYPE_III: target = Z_U1;
                        default:  target = Z_L2;
                    endcase
                end
            end

            // All zero states leave the same way
            Z_U2, Z_U1, Z_L1, Z_L2: begin
                if (level == V_POS) begin
                    target = P;
                end else if (level == V_NEG) begin
                    target = N;
                end
            end
        endcase
    end

endmodule

// ==== src/step_timer.sv ====
`timescale 1ns/10ps

module step_timer import anpc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  dwell_set_t dwells,
    input  dwell_sel_t dwell,
    input  logic       start,
    input  logic       advance,
    output logic       step_done
);

    dwell_t dwell_val;   // Active dwell time
    dwell_t last_count;  // Count value of the final cycle
    dwell_t count;

    always_comb begin
        case (dwell)
            DW_SHORT:     dwell_val = dwells.t_short;
            DW_OFF_ON:    dwell_val = dwells.t_off_on;
            DW_ON_OFF_V0: dwell_val = dwells.t_on_off_v0;
            default:      dwell_val = dwells.t_off_on_i0;
        endcase
    end

    // Zero dwell behaves as a single cycle
    assign last_count = (dwell_val == '0) ? '0 : dwell_val - 1'b1;

    assign step_done = advance && (count == last_count);

    //////////////////////////////////////////////////
    // Cycle counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (start || !advance) begin
            count <= '0;  // Parked at zero outside a sequence
        end else if (step_done) begin
            count <= '0;  // Wrap for the next step
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== src/commutation_table.sv ====
`timescale 1ns/10ps

module commutation_table import anpc_pkg::*; (
    input  anpc_state_t state,
    input  anpc_state_t dest,
    input  logic        busy,
    input  step_idx_t   step,
    output comm_step_t  entry
);

    // Gate word held while resting in a state
    function automatic gate_word_t steady_word(anpc_state_t s);
        case (s)
            P:       return 6'b110_001;
            Z_U2:    return 6'b010_010;
            Z_U1:    return 6'b010_110;
            Z_L1:    return 6'b101_001;
            Z_L2:    return 6'b001_001;
            N:       return 6'b001_110;
            default: return 6'b010_010;
        endcase
    endfunction

    function automatic comm_step_t make_step(gate_word_t g, dwell_sel_t d, logic l);
        return '{gates: g, dwell: d, last: l};
    endfunction

    //////////////////////////////////////////////////
    // Sequence lookup
    //////////////////////////////////////////////////

    always_comb begin
        entry = make_step(steady_word(state), DW_SHORT, 1'b0);
        if (busy) begin
            // Ends any step index not listed below
            entry = make_step(steady_word(dest), DW_SHORT, 1'b1);
            case (state)
                Z_U2: begin
                    case (dest)
                        P: case (step)
                            2'd0: entry = make_step(6'b010_000, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b110_000, DW_SHORT, 1'b0);
                            2'd2: entry = make_step(6'b110_001, DW_SHORT, 1'b1);
                        endcase
                        N: case (step)
                            2'd0: entry = make_step(6'b011_010, DW_SHORT, 1'b0);
                            2'd1: entry = make_step(6'b001_010, DW_OFF_ON, 1'b0);
                            2'd2: entry = make_step(6'b001_110, DW_SHORT, 1'b1);
                        endcase
                    endcase
                end

                Z_U1: begin
                    case (dest)
                        P: case (step)  // Waits for zero current first
                            2'd0: entry = make_step(6'b010_010, DW_OFF_ON_I0, 1'b0);
                            2'd1: entry = make_step(6'b010_011, DW_SHORT, 1'b0);
                            2'd2: entry = make_step(6'b010_001, DW_OFF_ON, 1'b0);
                            2'd3: entry = make_step(6'b110_001, DW_SHORT, 1'b1);
                        endcase
                        N: case (step)
                            2'd0: entry = make_step(6'b000_110, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b001_110, DW_SHORT, 1'b1);
                        endcase
                    endcase
                end

                Z_L1: begin
                    case (dest)
                        P: case (step)
                            2'd0: entry = make_step(6'b100_001, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b110_001, DW_SHORT, 1'b1);
                        endcase
                        N: case (step)
                            2'd0: entry = make_step(6'b001_001, DW_OFF_ON_I0, 1'b0);
                            2'd1: entry = make_step(6'b001_011, DW_SHORT, 1'b0);
                            2'd2: entry = make_step(6'b001_010, DW_OFF_ON, 1'b0);
                            2'd3: entry = make_step(6'b001_110, DW_SHORT, 1'b1);
                        endcase
                    endcase
                end

                Z_L2: begin
                    case (dest)
                        P: case (step)
                            2'd0: entry = make_step(6'b011_001, DW_SHORT, 1'b0);
                            2'd1: entry = make_step(6'b010_001, DW_OFF_ON, 1'b0);
                            2'd2: entry = make_step(6'b110_001, DW_SHORT, 1'b1);
                        endcase
                        N: case (step)
                            2'd0: entry = make_step(6'b001_000, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b001_100, DW_SHORT, 1'b0);
                            2'd2: entry = make_step(6'b001_110, DW_SHORT, 1'b1);
                        endcase
                    endcase
                end

                P: begin
                    case (dest)
                        Z_U2: case (step)
                            2'd0: entry = make_step(6'b110_000, DW_SHORT, 1'b0);
                            2'd1: entry = make_step(6'b010_000, DW_OFF_ON, 1'b0);
                            2'd2: entry = make_step(6'b010_010, DW_SHORT, 1'b1);
                        endcase
                        Z_L1: case (step)
                            2'd0: entry = make_step(6'b100_001, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b101_001, DW_SHORT, 1'b1);
                        endcase
                        Z_L2: case (step)
                            2'd0: entry = make_step(6'b010_001, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b011_001, DW_SHORT, 1'b0);
                            2'd2: entry = make_step(6'b001_001, DW_SHORT, 1'b1);
                        endcase
                    endcase
                end

                N: begin
                    case (dest)
                        Z_U2: case (step)  // Only user of the V0 dwell
                            2'd0: entry = make_step(6'b001_010, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b011_010, DW_ON_OFF_V0, 1'b0);
                            2'd2: entry = make_step(6'b010_010, DW_SHORT, 1'b1);
                        endcase
                        Z_U1: case (step)
                            2'd0: entry = make_step(6'b000_110, DW_OFF_ON, 1'b0);
                            2'd1: entry = make_step(6'b010_110, DW_SHORT, 1'b1);
                        endcase
                        Z_L2: case (step)
                            2'd0: entry = make_step(6'b001_100, DW_SHORT, 1'b0);
                            2'd1: entry = make_step(6'b001_000, DW_OFF_ON, 1'b0);
                            2'd2: entry = make_step(6'b001_001, DW_SHORT, 1'b1);
                        endcase
                    endcase
                end
            endcase
        end
    end

endmodule

// ==== src/commutation_ctrl.sv ====
`timescale 1ns/10ps

module commutation_ctrl import anpc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  anpc_state_t target,
    input  comm_step_t  entry,
    input  logic        step_done,
    output anpc_state_t state,
    output anpc_state_t dest,
    output logic        busy,
    output step_idx_t   step,
    output logic        start,
    output logic        advance,
    output gate_word_t  gates
);

    typedef enum logic {
        IDLE,
        COMMUTATE
    } phase_t;

    phase_t phase;

    //////////////////////////////////////////////////
    // Status and handoff to the step timer
    //////////////////////////////////////////////////

    assign busy    = (phase == COMMUTATE);
    assign advance = busy;  // Timer runs only inside a sequence

    // One cycle wide, the next cycle is already busy
    assign start = (phase == IDLE) && (target != state);

    //////////////////////////////////////////////////
    // Phase FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= IDLE;
            state <= RESET_STATE;
            dest  <= RESET_STATE;
            step  <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    // Target is frozen here for the whole sequence
                    if (start) begin
                        phase <= COMMUTATE;
                        dest  <= target;
                        step  <= '0;
                    end
                end

                COMMUTATE: begin
                    if (step_done) begin
                        if (entry.last) begin
                            state <= dest;  // Commit new switching state
                            phase <= IDLE;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end

                default: begin
                    phase <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Gate output register
    //////////////////////////////////////////////////

    // One cycle behind the table, glitch free towards the drivers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gates <= 6'b010_010;  // Steady word of Z_U2
        end else begin
            gates <= entry.gates;
        end
    end

endmodule

// ==== src/anpc_sequencer.sv ====
`timescale 1ns/10ps

module anpc_sequencer import anpc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  v_level_t   level,
    input  comm_type_t comm_type,
    input  dwell_set_t dwells,
    output gate_word_t gates
);

    anpc_state_t state;
    anpc_state_t target;
    anpc_state_t dest;
    logic        busy;
    step_idx_t   step;
    comm_step_t  entry;
    logic        start;
    logic        advance;
    logic        step_done;

    commutation_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .target    (target),
        .entry     (entry),
        .step_done (step_done),
        .state     (state),
        .dest      (dest),
        .busy      (busy),
        .step      (step),
        .start     (start),
        .advance   (advance),
        .gates     (gates)
    );

    target_select u_target (
        .state     (state),
        .level     (level),
        .comm_type (comm_type),
        .target    (target)
    );

    step_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .dwells    (dwells),
        .dwell     (entry.dwell),  // Dwell kind of the current step
        .start     (start),
        .advance   (advance),
        .step_done (step_done)
    );

    commutation_table u_table (
        .state (state),
        .dest  (dest),
        .busy  (busy),
        .step  (step),
        .entry (entry)
    );

endmodule

// ==== test/tb_anpc_vectors.svh ====
`ifndef TB_ANPC_VECTORS_SVH
`define TB_ANPC_VECTORS_SVH

// Each command starts where the previous one left the leg
// Gate words in octal with one digit per switch group (upper, lower)
// A hold of 0 leaves that run unchecked (the settled steady word)
// Old steady word stays 2 cycles after the drive edge, one to start and one in the gate register

localparam int NUM_CMDS = 21;
localparam int NUM_RUNS = 77;

typedef struct packed {
    v_level_t   level;
    comm_type_t ctype;
    v_level_t   late_level;  // Applied late_cycle edges after the command
    comm_type_t late_type;
    logic [3:0] late_cycle;  // 0 means no late change
    logic [3:0] num_runs;    // Expected gate runs for this command
} cmd_t;

typedef struct packed {
    gate_word_t word;
    dwell_t     hold;
} run_t;

// Short 2, off_on 3, on_off_v0 4, off_on_i0 5
localparam dwell_set_t TB_DWELLS = '{8'd2, 8'd3, 8'd4, 8'd5};

// level, type, late level, late type, late cycle, number of runs
localparam cmd_t CMDS [NUM_CMDS] = '{
    '{V_ZERO, TYPE_I,   V_ZERO, TYPE_I,  4'd0, 4'd1},  // Reset state holds
    '{V_POS,  TYPE_I,   V_ZERO, TYPE_I,  4'd0, 4'd4},  // Z_U2 to P
    '{V_ZERO, TYPE_I,   V_ZERO, TYPE_I,  4'd0, 4'd4},  // P to Z_U2
    '{V_NEG,  TYPE_I,   V_ZERO, TYPE_I,  4'd0, 4'd4},  // Z_U2 to N
    '{V_ZERO, TYPE_I,   V_ZERO, TYPE_I,  4'd0, 4'd4},  // N to Z_L2
    '{V_POS,  TYPE_II,  V_ZERO, TYPE_I,  4'd0, 4'd4},  // Z_L2 to P
    '{V_ZERO, TYPE_II,  V_ZERO, TYPE_I,  4'd0, 4'd4},  // P to Z_L2
    '{V_NEG,  TYPE_II,  V_ZERO, TYPE_I,  4'd0, 4'd4},  // Z_L2 to N
    '{V_ZERO, TYPE_II,  V_ZERO, TYPE_I,  4'd0, 4'd4},  // N to Z_U2
    '{V_POS,  TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd4},  // Z_U2 to P
    '{V_ZERO, TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd3},  // P to Z_L1
    '{V_NEG,  TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd5},  // Z_L1 to N
    '{V_ZERO, TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd3},  // N to Z_U1
    '{V_NEG,  TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd3},  // Z_U1 to N
    '{V_ZERO, TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd3},  // N to Z_U1
    '{V_POS,  TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd5},  // Z_U1 to P
    '{V_POS,  TYPE_I,   V_ZERO, TYPE_I,  4'd0, 4'd1},  // Already in P
    '{V_ZERO, TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd3},  // P to Z_L1
    '{V_POS,  TYPE_III, V_ZERO, TYPE_I,  4'd0, 4'd3},  // Z_L1 to P
    '{V_ZERO, TYPE_I,   V_ZERO, TYPE_I,  4'd0, 4'd4},  // P to Z_U2
    '{V_POS,  TYPE_I,   V_ZERO, TYPE_II, 4'd2, 4'd7}   // Late change mid sequence
};

// Expected runs with one line per command in the order above
localparam run_t RUNS [NUM_RUNS] = '{
    '{6'o22, 8'd0},
    '{6'o22, 8'd2}, '{6'o20, 8'd3}, '{6'o60, 8'd2}, '{6'o61, 8'd0},
    '{6'o61, 8'd2}, '{6'o60, 8'd2}, '{6'o20, 8'd3}, '{6'o22, 8'd0},
    '{6'o22, 8'd2}, '{6'o32, 8'd2}, '{6'o12, 8'd3}, '{6'o16, 8'd0},
    '{6'o16, 8'd2}, '{6'o14, 8'd2}, '{6'o10, 8'd3}, '{6'o11, 8'd0},
    '{6'o11, 8'd2}, '{6'o31, 8'd2}, '{6'o21, 8'd3}, '{6'o61, 8'd0},
    '{6'o61, 8'd2}, '{6'o21, 8'd3}, '{6'o31, 8'd2}, '{6'o11, 8'd0},
    '{6'o11, 8'd2}, '{6'o10, 8'd3}, '{6'o14, 8'd2}, '{6'o16, 8'd0},
    '{6'o16, 8'd2}, '{6'o12, 8'd3}, '{6'o32, 8'd4}, '{6'o22, 8'd0},
    '{6'o22, 8'd2}, '{6'o20, 8'd3}, '{6'o60, 8'd2}, '{6'o61, 8'd0},
    '{6'o61, 8'd2}, '{6'o41, 8'd3}, '{6'o51, 8'd0},
    '{6'o51, 8'd2}, '{6'o11, 8'd5}, '{6'o13, 8'd2}, '{6'o12, 8'd3}, '{6'o16, 8'd0},
    '{6'o16, 8'd2}, '{6'o06, 8'd3}, '{6'o26, 8'd0},
    '{6'o26, 8'd2}, '{6'o06, 8'd3}, '{6'o16, 8'd0},
    '{6'o16, 8'd2}, '{6'o06, 8'd3}, '{6'o26, 8'd0},
    '{6'o26, 8'd2}, '{6'o22, 8'd5}, '{6'o23, 8'd2}, '{6'o21, 8'd3}, '{6'o61, 8'd0},
    '{6'o61, 8'd0},
    '{6'o61, 8'd2}, '{6'o41, 8'd3}, '{6'o51, 8'd0},
    '{6'o51, 8'd2}, '{6'o41, 8'd3}, '{6'o61, 8'd0},
    '{6'o61, 8'd2}, '{6'o60, 8'd2}, '{6'o20, 8'd3}, '{6'o22, 8'd0},
    // Last step of Z_U2 to P merges with P steady for one extra cycle
    '{6'o22, 8'd2}, '{6'o20, 8'd3}, '{6'o60, 8'd2}, '{6'o61, 8'd3},
    '{6'o21, 8'd3}, '{6'o31, 8'd2}, '{6'o11, 8'd0}
};

`endif

// ==== test/tb_anpc_sequencer.sv ====
`timescale 1ns/10ps

module tb_anpc_sequencer import anpc_pkg::*; ();

    localparam int SETTLE_CYCLES  = 8;    // Steady word must hold this long
    localparam int TIMEOUT_CYCLES = 200;  // Per command
    localparam int MAX_SEEN       = 16;

    `include "tb_anpc_vectors.svh"

    logic       clk;
    logic       rst;
    v_level_t   level;
    comm_type_t comm_type;
    dwell_set_t dwells;
    gate_word_t gates;

    int   checks;
    int   errors;
    int   cmd_fails;
    int   base;
    logic timed_out;

    anpc_sequencer uut (
        .clk       (clk),
        .rst       (rst),
        .level     (level),
        .comm_type (comm_type),
        .dwells    (dwells),
        .gates     (gates)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_gates(input gate_word_t got, input gate_word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s gate word %b_%b, expected %b_%b",
                     $time, what, got[5:3], got[2:0], exp[5:3], exp[2:0]);
        end
    endtask

    task automatic check_hold(input dwell_t got, input dwell_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s held %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // One command: drive, record gate runs, compare
    //////////////////////////////////////////////////

    task automatic run_command(input int c, input int first);
        gate_word_t seen_word [MAX_SEEN];
        int         seen_hold [MAX_SEEN];
        int         n_seen;
        int         n_exp;
        int         cyc;
        int         err_before;
        int         i;
        logic       settled;
        gate_word_t sample;
        gate_word_t final_word;

        n_exp      = CMDS[c].num_runs;
        final_word = RUNS[first + n_exp - 1].word;
        err_before = errors;
        n_seen     = 0;
        cyc        = 0;
        settled    = 1'b0;

        @(posedge clk);
        level     <= CMDS[c].level;
        comm_type <= CMDS[c].ctype;

        while (!settled && !timed_out) begin
            @(negedge clk);  // Gates is stable mid cycle
            sample = gates;
            if (n_seen > 0 && sample == seen_word[n_seen-1]) begin
                seen_hold[n_seen-1]++;
            end else if (n_seen < MAX_SEEN) begin
                seen_word[n_seen] = sample;
                seen_hold[n_seen] = 1;
                n_seen++;
            end
            if (sample == final_word && seen_hold[n_seen-1] >= SETTLE_CYCLES) begin
                settled = 1'b1;
            end
            cyc++;
            if (!settled) begin
                if (cyc >= TIMEOUT_CYCLES) begin
                    timed_out = 1'b1;
                    $display("Timeout in command %0d: gate word never settled at %b_%b",
                             c, final_word[5:3], final_word[2:0]);
                end else begin
                    @(posedge clk);
                    if (CMDS[c].late_cycle != 0 && cyc == CMDS[c].late_cycle) begin
                        level     <= CMDS[c].late_level;  // Must not disturb the running sequence
                        comm_type <= CMDS[c].late_type;
                    end
                end
            end
        end

        if (!timed_out) begin
            if (n_seen != n_exp) begin
                errors++;
                $display("MISMATCH at %0t: command %0d gave %0d gate runs, expected %0d",
                         $time, c, n_seen, n_exp);
            end
            for (i = 0; i < n_seen && i < n_exp; i++) begin
                check_gates(seen_word[i], RUNS[first + i].word,
                            $sformatf("command %0d run %0d", c, i));
                if (RUNS[first + i].hold != 0) begin
                    check_hold(dwell_t'(seen_hold[i]), RUNS[first + i].hold,
                               $sformatf("command %0d run %0d", c, i));
                end
            end
        end

        if (errors == err_before && !timed_out) begin
            $display("command %0d (%s, %s): ok, %0d runs",
                     c, CMDS[c].level.name(), CMDS[c].ctype.name(), n_seen);
        end else begin
            cmd_fails++;
            $display("command %0d (%s, %s): failed",
                     c, CMDS[c].level.name(), CMDS[c].ctype.name());
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        $timeformat(-9, 1, " ns", 0);
        checks    = 0;
        errors    = 0;
        cmd_fails = 0;
        timed_out = 1'b0;
        rst       = 1'b1;
        level     = V_ZERO;
        comm_type = TYPE_I;
        dwells    = TB_DWELLS;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        base = 0;
        for (int c = 0; c < NUM_CMDS && !timed_out; c++) begin
            run_command(c, base);
            base += CMDS[c].num_runs;
        end

        $display("commands %0d, failed %0d, checks %0d, errors %0d",
                 NUM_CMDS, cmd_fails, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== anpc_sequencer.f ====
+incdir+test
common/anpc_pkg.sv
src/target_select.sv
src/step_timer.sv
src/commutation_table.sv
src/commutation_ctrl.sv
src/anpc_sequencer.sv
test/tb_anpc_sequencer.sv

// ==== Bender.yml ====
package:
  name: anpc_sequencer

sources:
  - files:
      - common/anpc_pkg.sv
      - src/target_select.sv
      - src/step_timer.sv
      - src/commutation_table.sv
      - src/commutation_ctrl.sv
      - src/anpc_sequencer.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_anpc_sequencer.sv
